// ==== snf_config.svh ====
/*
 * CHI-E subordinate node model configuration.
 * Node IDs, opcodes, flit field positions and memory geometry.
 */
`ifndef SNF_CONFIG_SVH
`define SNF_CONFIG_SVH

`define SNF_SN_ID                 7'h10
`define SNF_HN_ID                 7'h01

// request opcodes
`define SNF_OP_READNOSNP          7'h04
`define SNF_OP_WRITENOSNPPTL      7'h1C
`define SNF_OP_WRITENOSNPFULL     7'h1D

// data and response opcodes
`define SNF_OP_NONCOPYBACKWRDATA  4'h3
`define SNF_OP_COMPDATA           4'h4
`define SNF_OP_COMPDBIDRESP       5'h05
`define SNF_OP_READRECEIPT        5'h08
`define SNF_RESP_UC               3'b010

`define SNF_NODEID_W              7
`define SNF_TXNID_W               12
`define SNF_ADDR_W                48
`define SNF_BEAT_W                256
`define SNF_BE_W                  32
`define SNF_LINE_OFFSET           6
`define SNF_MEM_DEPTH             64

// request flit, cut to the fields read here
`define SNF_REQ_SRCID_RANGE       6:0
`define SNF_REQ_TXNID_RANGE       18:7
`define SNF_REQ_RETURNNID_RANGE   25:19
`define SNF_REQ_RETURNTXNID_RANGE 37:26
`define SNF_REQ_OPCODE_RANGE      44:38
`define SNF_REQ_ORDER_RANGE       46:45
`define SNF_REQ_ADDR_RANGE        94:47
`define SNF_REQ_FLIT_W            95

// data flit
`define SNF_DAT_TGTID_RANGE       6:0
`define SNF_DAT_SRCID_RANGE       13:7
`define SNF_DAT_TXNID_RANGE       25:14
`define SNF_DAT_HOMENID_RANGE     32:26
`define SNF_DAT_OPCODE_RANGE      36:33
`define SNF_DAT_RESP_RANGE        39:37
`define SNF_DAT_DBID_RANGE        51:40
`define SNF_DAT_DATAID_RANGE      53:52
`define SNF_DAT_BE_RANGE          85:54
`define SNF_DAT_DATA_RANGE        341:86
`define SNF_DAT_FLIT_W            342

// response flit
`define SNF_RSP_TGTID_RANGE       6:0
`define SNF_RSP_SRCID_RANGE       13:7
`define SNF_RSP_TXNID_RANGE       25:14
`define SNF_RSP_OPCODE_RANGE      30:26
`define SNF_RSP_FLIT_W            31

`endif

// ==== snf_pkg.sv ====
/*
 * Subordinate node types.
 * Memory line, data beat, line index and opcode types.
 */
`default_nettype none
`include "snf_config.svh"

package snf_pkg;

    typedef logic [`SNF_BEAT_W-1:0]             snf_beat_t;
    typedef logic [$clog2(`SNF_MEM_DEPTH)-1:0]  snf_line_idx_t;

    typedef logic [6:0]                         snf_req_op_t;
    typedef logic [3:0]                         snf_dat_op_t;
    typedef logic [4:0]                         snf_rsp_op_t;

    // one 64-byte line, beat 0 is the low half
    typedef union packed {
        logic [2*`SNF_BEAT_W-1:0] flat;
        snf_beat_t [1:0]          beat;
    } snf_line_u;

endpackage

`default_nettype wire

// ==== snf_rx_decode.sv ====
/*
 * Request and write data decoder.
 * Matches opcodes, captures request fields, gathers write beats
 * and drives the line memory port.
 */
`timescale 1ns/1ps
`default_nettype none
`include "snf_config.svh"

module snf_rx_decode import snf_pkg::*; (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        RXREQFLITV,
    input  logic [`SNF_REQ_FLIT_W-1:0]  RXREQFLIT,
    input  logic                        RXDATFLITV,
    input  logic [`SNF_DAT_FLIT_W-1:0]  RXDATFLIT,
    output logic                        rd_req,
    output logic                        wr_req,
    output logic [`SNF_NODEID_W-1:0]    req_srcid,
    output logic [`SNF_TXNID_W-1:0]     req_txnid,
    output logic [`SNF_NODEID_W-1:0]    req_return_nid,
    output logic [`SNF_TXNID_W-1:0]     req_return_txnid,
    output logic [1:0]                  req_order,
    output snf_line_idx_t               mem_idx,
    output logic                        mem_rd_en,
    output logic                        mem_wr_en,
    output snf_line_u                   mem_wr_line
);
    localparam int IDX_W = $bits(snf_line_idx_t);

    snf_req_op_t            req_op;
    snf_dat_op_t            dat_op;
    logic [1:0]             dat_id;
    logic [`SNF_ADDR_W-1:0] req_addr;
    snf_line_idx_t          req_idx;
    snf_line_idx_t          wr_idx_q;
    logic                   wr_data;
    logic                   wr_beat0;
    logic                   wr_beat1;

    assign req_op   = RXREQFLIT[`SNF_REQ_OPCODE_RANGE];
    assign req_addr = RXREQFLIT[`SNF_REQ_ADDR_RANGE];
    assign req_idx  = req_addr[`SNF_LINE_OFFSET +: IDX_W];
    assign dat_op   = RXDATFLIT[`SNF_DAT_OPCODE_RANGE];
    assign dat_id   = RXDATFLIT[`SNF_DAT_DATAID_RANGE];

    assign rd_req = RXREQFLITV && (req_op == `SNF_OP_READNOSNP);
    assign wr_req = RXREQFLITV && (req_op == `SNF_OP_WRITENOSNPFULL ||
                                   req_op == `SNF_OP_WRITENOSNPPTL);

    assign wr_data  = RXDATFLITV && (dat_op == `SNF_OP_NONCOPYBACKWRDATA);
    assign wr_beat0 = wr_data && (dat_id == 2'b00);
    assign wr_beat1 = wr_data && (dat_id == 2'b10);

    // fields held for the response and data generators
    always_ff @(posedge CLK) begin
        if (RXREQFLITV) begin
            req_srcid        <= RXREQFLIT[`SNF_REQ_SRCID_RANGE];
            req_txnid        <= RXREQFLIT[`SNF_REQ_TXNID_RANGE];
            req_return_nid   <= RXREQFLIT[`SNF_REQ_RETURNNID_RANGE];
            req_return_txnid <= RXREQFLIT[`SNF_REQ_RETURNTXNID_RANGE];
            req_order        <= RXREQFLIT[`SNF_REQ_ORDER_RANGE];
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_req) begin
            wr_idx_q <= req_idx;
        end
        if (wr_beat0) begin
            mem_wr_line.beat[0] <= RXDATFLIT[`SNF_DAT_DATA_RANGE];
        end
        if (wr_beat1) begin
            mem_wr_line.beat[1] <= RXDATFLIT[`SNF_DAT_DATA_RANGE];
        end
    end

    // second beat with no bytes enabled cancels the write
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            mem_wr_en <= 1'b0;
        end else begin
            mem_wr_en <= wr_beat1 && (|RXDATFLIT[`SNF_DAT_BE_RANGE]);
        end
    end

    // pending write owns the port
    assign mem_idx   = mem_wr_en ? wr_idx_q : req_idx;
    assign mem_rd_en = rd_req && !mem_wr_en;

    a_dataid_legal: assert property (@(posedge CLK) disable iff (RST)
        RXDATFLITV |-> (dat_id == 2'b00 || dat_id == 2'b10));

    a_no_req_during_write: assert property (@(posedge CLK) disable iff (RST)
        mem_wr_en |-> !RXREQFLITV);

endmodule

`default_nettype wire

// ==== snf_line_mem.sv ====
/*
 * Line storage.
 * Synchronous full-line write and a registered read that holds its value.
 */
`timescale 1ns/1ps
`default_nettype none
`include "snf_config.svh"

module snf_line_mem import snf_pkg::*; (
    input  logic          CLK,
    input  snf_line_idx_t mem_idx,
    input  logic          mem_rd_en,
    input  logic          mem_wr_en,
    input  snf_line_u     mem_wr_line,
    output snf_line_u     mem_rd_line
);
    logic [2*`SNF_BEAT_W-1:0] mem [`SNF_MEM_DEPTH];

    always_ff @(posedge CLK) begin
        if (mem_wr_en) begin
            mem[mem_idx] <= mem_wr_line.flat;
        end
    end

    // read data stays put until the next read
    always_ff @(posedge CLK) begin
        if (mem_rd_en) begin
            mem_rd_line.flat <= mem[mem_idx];
        end
    end

    a_port_exclusive: assert property (@(posedge CLK)
        !(mem_rd_en && mem_wr_en));

endmodule

`default_nettype wire

// ==== snf_rsp_gen.sv ====
/*
 * Response flit generator.
 * CompDBIDResp for writes, ReadReceipt for ordered reads.
 */
`timescale 1ns/1ps
`default_nettype none
`include "snf_config.svh"

module snf_rsp_gen import snf_pkg::*; (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        rd_req,
    input  logic                        wr_req,
    input  logic [`SNF_NODEID_W-1:0]    req_srcid,
    input  logic [`SNF_TXNID_W-1:0]     req_txnid,
    input  logic [1:0]                  req_order,
    output logic                        TXRSPFLITV,
    output logic [`SNF_RSP_FLIT_W-1:0]  TXRSPFLIT
);
    logic                       rd_q;
    logic                       wr_q;
    logic                       send_rsp;
    snf_rsp_op_t                rsp_op;
    logic [`SNF_RSP_FLIT_W-1:0] rsp_flit;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            rd_q <= rd_req;
            wr_q <= wr_req;
        end
    end

    // receipt only when the read asked for ordering
    assign send_rsp = wr_q || (rd_q && req_order == 2'b01);
    assign rsp_op   = wr_q ? `SNF_OP_COMPDBIDRESP : `SNF_OP_READRECEIPT;

    always_comb begin
        rsp_flit                        = '0;
        rsp_flit[`SNF_RSP_TGTID_RANGE]  = req_srcid;
        rsp_flit[`SNF_RSP_SRCID_RANGE]  = `SNF_SN_ID;
        rsp_flit[`SNF_RSP_TXNID_RANGE]  = req_txnid;
        rsp_flit[`SNF_RSP_OPCODE_RANGE] = rsp_op;
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            TXRSPFLITV <= 1'b0;
        end else begin
            TXRSPFLITV <= send_rsp;
        end
    end

    always_ff @(posedge CLK) begin
        if (send_rsp) begin
            TXRSPFLIT <= rsp_flit;
        end
    end

endmodule

`default_nettype wire

// ==== snf_dat_gen.sv ====
/*
 * CompData generator.
 * Sends the read line as two beats, DataID 00 then 10, state UC.
 */
`timescale 1ns/1ps
`default_nettype none
`include "snf_config.svh"

module snf_dat_gen import snf_pkg::*; (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        rd_req,
    input  logic [`SNF_TXNID_W-1:0]     req_txnid,
    input  logic [`SNF_TXNID_W-1:0]     req_return_txnid,
    input  logic [`SNF_NODEID_W-1:0]    req_return_nid,
    input  snf_line_u                   mem_rd_line,
    output logic                        TXDATFLITV,
    output logic [`SNF_DAT_FLIT_W-1:0]  TXDATFLIT
);
    logic                       send_beat0;
    logic                       send_beat1;
    logic [`SNF_DAT_FLIT_W-1:0] beat0_flit;
    logic [`SNF_DAT_FLIT_W-1:0] beat1_flit;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            send_beat0 <= 1'b0;
            send_beat1 <= 1'b0;
        end else begin
            send_beat0 <= rd_req;
            send_beat1 <= send_beat0;
        end
    end

    always_comb begin
        beat0_flit                         = '0;
        beat0_flit[`SNF_DAT_TGTID_RANGE]   = req_return_nid;
        beat0_flit[`SNF_DAT_SRCID_RANGE]   = `SNF_SN_ID;
        beat0_flit[`SNF_DAT_TXNID_RANGE]   = req_return_txnid;
        beat0_flit[`SNF_DAT_HOMENID_RANGE] = `SNF_HN_ID;
        beat0_flit[`SNF_DAT_OPCODE_RANGE]  = `SNF_OP_COMPDATA;
        beat0_flit[`SNF_DAT_RESP_RANGE]    = `SNF_RESP_UC;
        beat0_flit[`SNF_DAT_DBID_RANGE]    = req_txnid;
        beat0_flit[`SNF_DAT_DATAID_RANGE]  = 2'b00;
        beat0_flit[`SNF_DAT_BE_RANGE]      = {`SNF_BE_W{1'b1}};
        beat0_flit[`SNF_DAT_DATA_RANGE]    = mem_rd_line.beat[0];
    end

    // beat 1 reuses the header already on the channel
    always_comb begin
        beat1_flit                        = TXDATFLIT;
        beat1_flit[`SNF_DAT_DATAID_RANGE] = 2'b10;
        beat1_flit[`SNF_DAT_DATA_RANGE]   = mem_rd_line.beat[1];
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            TXDATFLITV <= 1'b0;
        end else begin
            TXDATFLITV <= send_beat0 || send_beat1;
        end
    end

    always_ff @(posedge CLK) begin
        if (send_beat0) begin
            TXDATFLIT <= beat0_flit;
        end else if (send_beat1) begin
            TXDATFLIT <= beat1_flit;
        end
    end

    a_beat1_follows: assert property (@(posedge CLK) disable iff (RST)
        (TXDATFLITV && TXDATFLIT[`SNF_DAT_DATAID_RANGE] == 2'b00) |=>
        (TXDATFLITV && TXDATFLIT[`SNF_DAT_DATAID_RANGE] == 2'b10));

endmodule

`default_nettype wire

// ==== snf_top.sv ====
/*
 * CHI-E subordinate node top level.
 * Decoder, line memory and the response and data generators.
 */
`timescale 1ns/1ps
`default_nettype none
`include "snf_config.svh"

module snf_top import snf_pkg::*; (
    input  logic                        CLK,
    input  logic                        RST,
    input  logic                        RXREQFLITV,
    input  logic [`SNF_REQ_FLIT_W-1:0]  RXREQFLIT,
    input  logic                        RXDATFLITV,
    input  logic [`SNF_DAT_FLIT_W-1:0]  RXDATFLIT,
    output logic                        TXRSPFLITV,
    output logic [`SNF_RSP_FLIT_W-1:0]  TXRSPFLIT,
    output logic                        TXDATFLITV,
    output logic [`SNF_DAT_FLIT_W-1:0]  TXDATFLIT
);
    logic                     rd_req;
    logic                     wr_req;
    logic [`SNF_NODEID_W-1:0] req_srcid;
    logic [`SNF_TXNID_W-1:0]  req_txnid;
    logic [`SNF_NODEID_W-1:0] req_return_nid;
    logic [`SNF_TXNID_W-1:0]  req_return_txnid;
    logic [1:0]               req_order;
    snf_line_idx_t            mem_idx;
    logic                     mem_rd_en;
    logic                     mem_wr_en;
    snf_line_u                mem_wr_line;
    snf_line_u                mem_rd_line;

    snf_rx_decode i_rx_decode (
        .CLK(CLK), .RST(RST),
        .RXREQFLITV(RXREQFLITV), .RXREQFLIT(RXREQFLIT),
        .RXDATFLITV(RXDATFLITV), .RXDATFLIT(RXDATFLIT),
        .rd_req(rd_req), .wr_req(wr_req),
        .req_srcid(req_srcid), .req_txnid(req_txnid),
        .req_return_nid(req_return_nid), .req_return_txnid(req_return_txnid),
        .req_order(req_order),
        .mem_idx(mem_idx), .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en),
        .mem_wr_line(mem_wr_line)
    );

    snf_line_mem i_line_mem (
        .CLK(CLK), .mem_idx(mem_idx), .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en),
        .mem_wr_line(mem_wr_line), .mem_rd_line(mem_rd_line)
    );

    snf_rsp_gen i_rsp_gen (
        .CLK(CLK), .RST(RST), .rd_req(rd_req), .wr_req(wr_req),
        .req_srcid(req_srcid), .req_txnid(req_txnid), .req_order(req_order),
        .TXRSPFLITV(TXRSPFLITV), .TXRSPFLIT(TXRSPFLIT)
    );

    snf_dat_gen i_dat_gen (
        .CLK(CLK), .RST(RST), .rd_req(rd_req),
        .req_txnid(req_txnid), .req_return_txnid(req_return_txnid),
        .req_return_nid(req_return_nid), .mem_rd_line(mem_rd_line),
        .TXDATFLITV(TXDATFLITV), .TXDATFLIT(TXDATFLIT)
    );

endmodule

`default_nettype wire

// ==== tb_snf_top.sv ====
/*
 * Testbench for the CHI-E subordinate node model.
 * Applies a table of writes and reads as flits and checks every
 * response and data flit against a reference line array.
 */
`timescale 1ns/1ps
`default_nettype none
`include "snf_config.svh"

module tb_snf_top;
    localparam int DAT_W    = `SNF_DAT_FLIT_W;
    localparam int RSP_W    = `SNF_RSP_FLIT_W;
    localparam int TIMEOUT  = 20;
    localparam int K_WRFULL = 0;
    localparam int K_WRPTL  = 1;
    localparam int K_READ   = 2;

    typedef struct {
        int                       kind;
        logic [5:0]               idx;
        logic [`SNF_TXNID_W-1:0]  txnid;
        logic [`SNF_NODEID_W-1:0] srcid;
        logic [`SNF_NODEID_W-1:0] rnid;
        logic [`SNF_TXNID_W-1:0]  rtxnid;
        logic [1:0]               order;
        bit                       cancel;
        logic [`SNF_BEAT_W-1:0]   b0;
        logic [`SNF_BEAT_W-1:0]   b1;
    } op_t;

    logic                        CLK = 1'b0;
    logic                        RST;
    logic                        RXREQFLITV;
    logic [`SNF_REQ_FLIT_W-1:0]  RXREQFLIT;
    logic                        RXDATFLITV;
    logic [DAT_W-1:0]            RXDATFLIT;
    logic                        TXRSPFLITV;
    logic [RSP_W-1:0]            TXRSPFLIT;
    logic                        TXDATFLITV;
    logic [DAT_W-1:0]            TXDATFLIT;

    op_t                         ops[$];
    logic [2*`SNF_BEAT_W-1:0]    ref_mem [`SNF_MEM_DEPTH];
    logic [RSP_W-1:0]            rsp_q[$];
    logic [DAT_W-1:0]            dat_q[$];
    int                          rsp_cyc_q[$];
    int                          dat_cyc_q[$];
    int                          cyc = 0;
    int                          req_cyc;
    int                          checks = 0;
    int                          errors = 0;
    int                          timeouts = 0;

    snf_top i_dut (
        .CLK(CLK), .RST(RST),
        .RXREQFLITV(RXREQFLITV), .RXREQFLIT(RXREQFLIT),
        .RXDATFLITV(RXDATFLITV), .RXDATFLIT(RXDATFLIT),
        .TXRSPFLITV(TXRSPFLITV), .TXRSPFLIT(TXRSPFLIT),
        .TXDATFLITV(TXDATFLITV), .TXDATFLIT(TXDATFLIT)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    // outputs are stable at the falling edge
    always @(negedge CLK) begin
        if (TXRSPFLITV) begin
            rsp_q.push_back(TXRSPFLIT);
            rsp_cyc_q.push_back(cyc);
        end
        if (TXDATFLITV) begin
            dat_q.push_back(TXDATFLIT);
            dat_cyc_q.push_back(cyc);
        end
    end

    task automatic check_flit(input string name, input logic [DAT_W-1:0] got, exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic logic [`SNF_BEAT_W-1:0] rand_beat();
        logic [`SNF_BEAT_W-1:0] r;
        for (int i = 0; i < `SNF_BEAT_W / 32; i++) begin
            r[32*i +: 32] = $urandom();
        end
        return r;
    endfunction

    task automatic add_op(input int kind, input logic [5:0] idx,
                          input logic [`SNF_TXNID_W-1:0] txnid,
                          input logic [`SNF_NODEID_W-1:0] srcid, rnid,
                          input logic [`SNF_TXNID_W-1:0] rtxnid,
                          input logic [1:0] order, input bit cancel);
        op_t o;
        o.kind   = kind;
        o.idx    = idx;
        o.txnid  = txnid;
        o.srcid  = srcid;
        o.rnid   = rnid;
        o.rtxnid = rtxnid;
        o.order  = order;
        o.cancel = cancel;
        o.b0     = rand_beat();
        o.b1     = rand_beat();
        ops.push_back(o);
    endtask

    function automatic logic [`SNF_REQ_FLIT_W-1:0] build_req(input op_t o);
        logic [`SNF_REQ_FLIT_W-1:0] f;
        f = '0;
        f[`SNF_REQ_SRCID_RANGE]       = o.srcid;
        f[`SNF_REQ_TXNID_RANGE]       = o.txnid;
        f[`SNF_REQ_RETURNNID_RANGE]   = o.rnid;
        f[`SNF_REQ_RETURNTXNID_RANGE] = o.rtxnid;
        f[`SNF_REQ_ORDER_RANGE]       = o.order;
        f[`SNF_REQ_ADDR_RANGE]        = 48'(o.idx) << `SNF_LINE_OFFSET;
        case (o.kind)
            K_WRFULL: f[`SNF_REQ_OPCODE_RANGE] = `SNF_OP_WRITENOSNPFULL;
            K_WRPTL:  f[`SNF_REQ_OPCODE_RANGE] = `SNF_OP_WRITENOSNPPTL;
            default:  f[`SNF_REQ_OPCODE_RANGE] = `SNF_OP_READNOSNP;
        endcase
        return f;
    endfunction

    function automatic logic [DAT_W-1:0] write_beat(input op_t o, input logic [1:0] dataid,
                                                    input logic [`SNF_BE_W-1:0] be,
                                                    input logic [`SNF_BEAT_W-1:0] data);
        logic [DAT_W-1:0] f;
        f = '0;
        f[`SNF_DAT_TGTID_RANGE]  = `SNF_SN_ID;
        f[`SNF_DAT_SRCID_RANGE]  = `SNF_HN_ID;
        f[`SNF_DAT_TXNID_RANGE]  = o.txnid;
        f[`SNF_DAT_OPCODE_RANGE] = `SNF_OP_NONCOPYBACKWRDATA;
        f[`SNF_DAT_DATAID_RANGE] = dataid;
        f[`SNF_DAT_BE_RANGE]     = be;
        f[`SNF_DAT_DATA_RANGE]   = data;
        return f;
    endfunction

    // response to the requester, all other fields zero
    function automatic logic [RSP_W-1:0] expected_rsp(input op_t o);
        logic [RSP_W-1:0] f;
        f = '0;
        f[`SNF_RSP_TGTID_RANGE]  = o.srcid;
        f[`SNF_RSP_SRCID_RANGE]  = `SNF_SN_ID;
        f[`SNF_RSP_TXNID_RANGE]  = o.txnid;
        f[`SNF_RSP_OPCODE_RANGE] = (o.kind == K_READ) ? `SNF_OP_READRECEIPT
                                                      : `SNF_OP_COMPDBIDRESP;
        return f;
    endfunction

    function automatic logic [DAT_W-1:0] expected_dat(input op_t o, input int k);
        logic [DAT_W-1:0] f;
        f = '0;
        f[`SNF_DAT_TGTID_RANGE]   = o.rnid;
        f[`SNF_DAT_SRCID_RANGE]   = `SNF_SN_ID;
        f[`SNF_DAT_TXNID_RANGE]   = o.rtxnid;
        f[`SNF_DAT_HOMENID_RANGE] = `SNF_HN_ID;
        f[`SNF_DAT_OPCODE_RANGE]  = `SNF_OP_COMPDATA;
        f[`SNF_DAT_RESP_RANGE]    = `SNF_RESP_UC;
        f[`SNF_DAT_DBID_RANGE]    = o.txnid;
        f[`SNF_DAT_DATAID_RANGE]  = (k == 1) ? 2'b10 : 2'b00;
        f[`SNF_DAT_BE_RANGE]      = {`SNF_BE_W{1'b1}};
        f[`SNF_DAT_DATA_RANGE]    = ref_mem[o.idx][k*`SNF_BEAT_W +: `SNF_BEAT_W];
        return f;
    endfunction

    // wait for the expected flits, then a few quiet cycles to catch extras
    task automatic collect_flits(input int n_rsp, input int n_dat);
        int t;
        t = 0;
        while ((rsp_q.size() < n_rsp || dat_q.size() < n_dat) && t < TIMEOUT) begin
            @(posedge CLK);
            t++;
        end
        if (rsp_q.size() < n_rsp || dat_q.size() < n_dat) begin
            timeouts++;
            $display("timed out at %0t waiting for response or data flits", $time);
        end
        repeat (3) @(posedge CLK);
        check_value("TXRSPFLITV count", rsp_q.size(), n_rsp);
        check_value("TXDATFLITV count", dat_q.size(), n_dat);
    endtask

    task automatic run_op(input op_t o);
        int n_rsp;
        int n_dat;
        n_rsp = (o.kind != K_READ || o.order == 2'b01) ? 1 : 0;
        n_dat = (o.kind == K_READ) ? 2 : 0;
        @(negedge CLK);
        RXREQFLITV = 1'b1;
        RXREQFLIT  = build_req(o);
        req_cyc    = cyc + 1;
        @(negedge CLK);
        RXREQFLITV = 1'b0;
        if (o.kind != K_READ) begin
            RXDATFLITV = 1'b1;
            RXDATFLIT  = write_beat(o, 2'b00, {`SNF_BE_W{1'b1}}, o.b0);
            @(negedge CLK);
            RXDATFLIT  = write_beat(o, 2'b10, o.cancel ? '0 : {`SNF_BE_W{1'b1}}, o.b1);
            @(negedge CLK);
            RXDATFLITV = 1'b0;
            if (!o.cancel) begin
                ref_mem[o.idx] = {o.b1, o.b0};
            end
        end
        collect_flits(n_rsp, n_dat);
        if (rsp_q.size() == n_rsp && dat_q.size() == n_dat) begin
            if (n_rsp == 1) begin
                check_value("TXRSPFLITV cycle", rsp_cyc_q[0], req_cyc + 1);
                check_flit("TXRSPFLIT", DAT_W'(rsp_q[0]), DAT_W'(expected_rsp(o)));
            end
            for (int k = 0; k < n_dat; k++) begin
                check_value("TXDATFLITV cycle", dat_cyc_q[k], req_cyc + 1 + k);
                check_flit("TXDATFLIT", dat_q[k], expected_dat(o, k));
            end
        end
        rsp_q.delete();
        rsp_cyc_q.delete();
        dat_q.delete();
        dat_cyc_q.delete();
    endtask

    initial begin
        RST        = 1'b1;
        RXREQFLITV = 1'b0;
        RXREQFLIT  = '0;
        RXDATFLITV = 1'b0;
        RXDATFLIT  = '0;
        void'($urandom(32'ha600_37f2));

        // kind, line, txnid, srcid, return nid, return txnid, order, cancel
        add_op(K_WRFULL, 6'd3,  12'h011, 7'h02, 7'h00, 12'h000, 2'b00, 1'b0);
        add_op(K_WRPTL,  6'd17, 12'h012, 7'h03, 7'h00, 12'h000, 2'b00, 1'b0);
        add_op(K_WRFULL, 6'd35, 12'h013, 7'h04, 7'h00, 12'h000, 2'b00, 1'b0);
        add_op(K_WRFULL, 6'd63, 12'h014, 7'h05, 7'h00, 12'h000, 2'b00, 1'b0);
        add_op(K_READ,   6'd35, 12'h021, 7'h01, 7'h22, 12'h3A1, 2'b00, 1'b0);
        add_op(K_READ,   6'd3,  12'h022, 7'h01, 7'h23, 12'h3A2, 2'b01, 1'b0);
        add_op(K_READ,   6'd63, 12'h023, 7'h01, 7'h24, 12'h3A3, 2'b01, 1'b0);
        add_op(K_READ,   6'd17, 12'h024, 7'h01, 7'h25, 12'h3A4, 2'b00, 1'b0);
        add_op(K_WRPTL,  6'd17, 12'h031, 7'h06, 7'h00, 12'h000, 2'b00, 1'b1);
        add_op(K_READ,   6'd17, 12'h032, 7'h01, 7'h26, 12'h3A5, 2'b01, 1'b0);
        add_op(K_WRFULL, 6'd3,  12'h033, 7'h07, 7'h00, 12'h000, 2'b00, 1'b0);
        add_op(K_READ,   6'd3,  12'h034, 7'h01, 7'h27, 12'hFFF, 2'b00, 1'b0);

        repeat (4) begin
            @(negedge CLK);
            check_value("TXRSPFLITV", 32'(TXRSPFLITV), 32'd0);
            check_value("TXDATFLITV", 32'(TXDATFLITV), 32'd0);
        end
        RST = 1'b0;
        repeat (3) @(negedge CLK);
        check_value("flits after reset", rsp_q.size() + dat_q.size(), 0);

        foreach (ops[i]) begin
            run_op(ops[i]);
        end

        $display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== snf.f ====
+incdir+.
snf_pkg.sv
snf_rx_decode.sv
snf_line_mem.sv
snf_rsp_gen.sv
snf_dat_gen.sv
snf_top.sv
tb_snf_top.sv

// ==== Makefile ====
# Verilator flow for the subordinate node model and its testbench

VERILATOR ?= verilator
TOP       ?= tb_snf_top
FILELIST  ?= snf.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass or fail is decided by the pass message in the simulation output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
